// File: include/decode_cfg.svh
// decode stage configuration
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

`define IQ_DEPTH     16   // instruction queue entries
`define FETCH_WIDTH  4    // instructions per fetch packet
`define ISSUE_WIDTH  2    // up and down slots
`define GPR_COUNT    32
`define STAGE_COUNT  4    // downstream stages that can forward

// major opcodes
`define OP_SPECIAL   6'b000000
`define OP_ADDIU     6'b001001
`define OP_ANDI      6'b001100
`define OP_ORI       6'b001101
`define OP_XORI      6'b001110
`define OP_LUI       6'b001111

// SPECIAL function field
`define FN_SLL       6'b000000
`define FN_SRL       6'b000010
`define FN_ADDU      6'b100001
`define FN_SUBU      6'b100011
`define FN_AND       6'b100100
`define FN_OR        6'b100101
`define FN_XOR       6'b100110
`define FN_SLT       6'b101010

`endif

// File: src/isaPkg.sv
// instruction set types
package isaPkg;

    typedef logic [4:0]  gprNum_t;
    typedef logic [31:0] word_t;

    typedef struct packed {
        logic [5:0] opcode;
        gprNum_t    rs;
        gprNum_t    rt;
        gprNum_t    rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } rType_t;

    typedef struct packed {
        logic [5:0]  opcode;
        gprNum_t     rs;
        gprNum_t     rt;
        logic [15:0] imm;
    } iType_t;

    // same 32 bits, register or immediate layout
    typedef union packed {
        rType_t rType;
        iType_t iType;
    } instWord_u;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } aluOp_e;

    typedef struct packed {
        aluOp_e  aluOp;
        gprNum_t writeNum;       // 0 means no write
        gprNum_t readNum0;       // rs
        gprNum_t readNum1;       // rt
        logic    needRead0;
        logic    needRead1;
        logic    operand0IsReg;
        logic    operand1IsReg;
        word_t   immediate;      // already extended
        word_t   shiftAmount;    // sa field, zero extended
    } decodedInst_t;

endpackage

// File: src/issuePkg.sv
// fetch and issue bundle types
`include "decode_cfg.svh"

package issuePkg;

    typedef struct packed {
        isaPkg::word_t                           basePc;
        logic [2:0]                              instCount;  // 1 to 4
        isaPkg::instWord_u [`FETCH_WIDTH-1:0]    inst;       // inst[0] at basePc
    } fetchPacket_t;

    typedef struct packed {
        isaPkg::word_t     pc;
        isaPkg::instWord_u inst;
    } queueEntry_t;

    typedef struct packed {
        isaPkg::gprNum_t writeNum;
        logic            ready;      // result can be forwarded now
    } stageWrite_t;

    // bit per stage, top bit selects the register file
    typedef logic [`STAGE_COUNT:0] fwdSel_t;

    typedef struct packed {
        logic up;
        logic down;
    } issueMode_t;

    typedef struct packed {
        isaPkg::word_t   pc;
        isaPkg::aluOp_e  aluOp;
        isaPkg::gprNum_t writeNum;
        isaPkg::word_t   readData0;
        isaPkg::word_t   readData1;
        isaPkg::word_t   operand0;
        isaPkg::word_t   operand1;
        logic            operand0IsReg;
        logic            operand1IsReg;
        fwdSel_t         fwdSel0;
        fwdSel_t         fwdSel1;
    } issueBundle_t;

endpackage

// File: src/instQueue.sv
// instruction queue
`timescale 1ns/10ps
`include "decode_cfg.svh"

module instQueue (
    input  logic                                          clk,
    input  logic                                          rst_i,
    input  logic                                          flush_i,
    input  logic                                          pushValid_i,
    input  issuePkg::fetchPacket_t                        pushPacket_i,
    input  logic [1:0]                                    popCount_i,
    output issuePkg::queueEntry_t [`ISSUE_WIDTH-1:0]      head_o,
    output logic [1:0]                                    headCount_o,
    output logic                                          stopFetch_o
);
    localparam int PTR_W = $clog2(`IQ_DEPTH);

    issuePkg::queueEntry_t entries [`IQ_DEPTH];
    logic [PTR_W-1:0]      rdPtr;
    logic [PTR_W-1:0]      wrPtr;
    logic [PTR_W-1:0]      rdPtrNext;
    logic [PTR_W:0]        count;
    logic [2:0]            pushCount;

    assign pushCount = pushValid_i ? pushPacket_i.instCount : 3'd0;
    assign rdPtrNext = rdPtr + PTR_W'(1);

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int k = 0; k < `FETCH_WIDTH; k++) begin
            if (k < int'(pushCount)) begin
                entries[wrPtr + PTR_W'(k)].pc   <= pushPacket_i.basePc + 32'(4 * k);
                entries[wrPtr + PTR_W'(k)].inst <= pushPacket_i.inst[k];
            end
        end
    end

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            rdPtr <= rdPtr + PTR_W'(popCount_i);
            wrPtr <= wrPtr + PTR_W'(pushCount);
            count <= count + (PTR_W+1)'(pushCount) - (PTR_W+1)'(popCount_i);
        end
    end

    assign head_o[0]   = entries[rdPtr];
    assign head_o[1]   = entries[rdPtrNext];    // only meaningful when count >= 2
    assign headCount_o = (count >= 2) ? 2'd2 : count[1:0];

    // room for a whole packet or fetch waits
    assign stopFetch_o = count > (PTR_W+1)'(`IQ_DEPTH - `FETCH_WIDTH);

    pushWhenFull: assert property (@(posedge clk) disable iff (rst_i)
        pushValid_i |-> !stopFetch_o);

    // pop count comes back from the hazard unit
    popWithinHead: assert property (@(posedge clk) disable iff (rst_i)
        popCount_i <= headCount_o);

endmodule

// File: src/instDecoder.sv
// integer ALU instruction decoder
`timescale 1ns/10ps
`include "decode_cfg.svh"

module instDecoder (
    input  isaPkg::instWord_u    inst_i,
    output isaPkg::decodedInst_t decoded_o
);
    isaPkg::aluOp_e op;
    logic           isSpecial;
    logic           isShift;

    assign isSpecial = inst_i.rType.opcode == `OP_SPECIAL;
    assign isShift   = op == isaPkg::ALU_SLL || op == isaPkg::ALU_SRL;

    always_comb begin
        op = isaPkg::ALU_NOP;   // anything outside the subset
        if (isSpecial) begin
            case (inst_i.rType.funct)
                `FN_ADDU: op = isaPkg::ALU_ADD;
                `FN_SUBU: op = isaPkg::ALU_SUB;
                `FN_AND:  op = isaPkg::ALU_AND;
                `FN_OR:   op = isaPkg::ALU_OR;
                `FN_XOR:  op = isaPkg::ALU_XOR;
                `FN_SLT:  op = isaPkg::ALU_SLT;
                `FN_SLL:  op = isaPkg::ALU_SLL;
                `FN_SRL:  op = isaPkg::ALU_SRL;
                default:  op = isaPkg::ALU_NOP;
            endcase
        end else begin
            case (inst_i.iType.opcode)
                `OP_ADDIU: op = isaPkg::ALU_ADD;
                `OP_ANDI:  op = isaPkg::ALU_AND;
                `OP_ORI:   op = isaPkg::ALU_OR;
                `OP_XORI:  op = isaPkg::ALU_XOR;
                `OP_LUI:   op = isaPkg::ALU_LUI;
                default:   op = isaPkg::ALU_NOP;
            endcase
        end
    end

    always_comb begin
        decoded_o             = '0;
        decoded_o.aluOp       = op;
        decoded_o.shiftAmount = {27'b0, inst_i.rType.sa};
        if (op != isaPkg::ALU_NOP) begin
            if (isSpecial) begin
                decoded_o.writeNum      = inst_i.rType.rd;
                decoded_o.readNum1      = inst_i.rType.rt;
                decoded_o.needRead1     = 1'b1;
                decoded_o.operand1IsReg = 1'b1;
                if (!isShift) begin          // shifts take sa in place of rs
                    decoded_o.readNum0      = inst_i.rType.rs;
                    decoded_o.needRead0     = 1'b1;
                    decoded_o.operand0IsReg = 1'b1;
                end
            end else begin
                decoded_o.writeNum = inst_i.iType.rt;
                if (op != isaPkg::ALU_LUI) begin
                    decoded_o.readNum0      = inst_i.iType.rs;
                    decoded_o.needRead0     = 1'b1;
                    decoded_o.operand0IsReg = 1'b1;
                end
                case (op)
                    isaPkg::ALU_ADD: decoded_o.immediate = {{16{inst_i.iType.imm[15]}},
                                                            inst_i.iType.imm};
                    isaPkg::ALU_LUI: decoded_o.immediate = {inst_i.iType.imm, 16'b0};
                    default:         decoded_o.immediate = {16'b0, inst_i.iType.imm};
                endcase
            end
        end
    end

endmodule

// File: src/issueArbiter.sv
// dual issue pairing
`timescale 1ns/10ps

module issueArbiter (
    input  logic [1:0]           headCount_i,
    input  isaPkg::decodedInst_t older_i,
    input  isaPkg::decodedInst_t younger_i,
    output issuePkg::issueMode_t mode_o
);
    logic dependent;

    // read after write inside the pair
    assign dependent = older_i.writeNum != '0 &&
        ((younger_i.needRead0 && younger_i.readNum0 == older_i.writeNum) ||
         (younger_i.needRead1 && younger_i.readNum1 == older_i.writeNum));

    always_comb begin
        case (headCount_i)
            2'd0: begin
                mode_o.up   = 1'b0;
                mode_o.down = 1'b0;
            end
            2'd1: begin
                mode_o.up   = 1'b1;
                mode_o.down = 1'b0;
            end
            default: begin
                mode_o.up   = 1'b1;
                mode_o.down = !dependent;   // younger waits a cycle
            end
        endcase
    end

endmodule

// File: src/regFile.sv
// general purpose register file
`timescale 1ns/10ps
`include "decode_cfg.svh"

module regFile (
    input  logic                        clk,
    input  logic                        rst_i,
    input  isaPkg::gprNum_t [3:0]       readNum_i,
    output isaPkg::word_t   [3:0]       readData_o,
    input  logic                        wbWe_i,
    input  isaPkg::gprNum_t             wbNum_i,
    input  isaPkg::word_t               wbData_i,
    input  logic                        pbaWe_i,
    input  isaPkg::gprNum_t             pbaNum_i,
    input  isaPkg::word_t               pbaData_i
);
    isaPkg::word_t regs [`GPR_COUNT];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int r = 0; r < `GPR_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (wbWe_i) regs[wbNum_i] <= wbData_i;
            if (pbaWe_i) regs[pbaNum_i] <= pbaData_i;   // pba last, wins a conflict
        end
    end

    // same-cycle write is visible to the read
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (readNum_i[p] == '0) readData_o[p] = '0;
            else if (pbaWe_i && pbaNum_i == readNum_i[p]) readData_o[p] = pbaData_i;
            else if (wbWe_i && wbNum_i == readNum_i[p]) readData_o[p] = wbData_i;
            else readData_o[p] = regs[readNum_i[p]];
        end
    end

endmodule

// File: src/hazardUnit.sv
// forwarding select and stall control
`timescale 1ns/10ps
`include "decode_cfg.svh"

module hazardUnit (
    input  issuePkg::issueMode_t                       mode_i,
    input  isaPkg::decodedInst_t                       up_i,
    input  isaPkg::decodedInst_t                       down_i,
    input  issuePkg::stageWrite_t [`STAGE_COUNT-1:0]   pipeWrites_i,
    input  logic                                       downstreamDanger_i,
    input  logic                                       allowIn_i,
    input  logic                                       flush_i,
    output issuePkg::fwdSel_t [3:0]                    fwdSel_o,
    output logic                                       upValid_o,
    output logic                                       downValid_o,
    output logic [1:0]                                 popCount_o
);
    isaPkg::gprNum_t [3:0] readNum;
    logic [3:0]            needRead;
    logic [3:0]            noSource;
    logic                  stall;
    logic                  issue;

    // operand order is up rs, up rt, down rs, down rt
    assign readNum  = {down_i.readNum1, down_i.readNum0, up_i.readNum1, up_i.readNum0};
    assign needRead = {down_i.needRead1 & mode_i.down, down_i.needRead0 & mode_i.down,
                       up_i.needRead1 & mode_i.up, up_i.needRead0 & mode_i.up};

    //////////////////////////////////////////////////
    // forwarding source per operand
    //////////////////////////////////////////////////
    always_comb begin
        for (int op = 0; op < 4; op++) begin
            fwdSel_o[op]               = '0;
            fwdSel_o[op][`STAGE_COUNT] = 1'b1;   // register file by default
            // oldest first so the youngest match overrides
            for (int s = `STAGE_COUNT - 1; s >= 0; s--) begin
                if (pipeWrites_i[s].writeNum != '0 &&
                    pipeWrites_i[s].writeNum == readNum[op]) begin
                    fwdSel_o[op]    = '0;
                    fwdSel_o[op][s] = pipeWrites_i[s].ready;
                end
            end
            noSource[op] = ~|fwdSel_o[op];
        end
    end

    //////////////////////////////////////////////////
    // stall and valids
    //////////////////////////////////////////////////
    assign stall       = |(needRead & noSource) || downstreamDanger_i;
    assign issue       = (mode_i.up || mode_i.down) && allowIn_i && !stall;
    assign upValid_o   = issue && mode_i.up && !flush_i;
    assign downValid_o = issue && mode_i.down && !flush_i;
    assign popCount_o  = {1'b0, upValid_o} + {1'b0, downValid_o};

endmodule

// File: src/decodeStage.sv
// decode and issue stage
`timescale 1ns/10ps
`include "decode_cfg.svh"

module decodeStage (
    input  logic                                       clk,
    input  logic                                       rst_i,
    input  logic                                       fetchValid_i,
    input  issuePkg::fetchPacket_t                     fetchPacket_i,
    input  logic                                       flush_i,
    input  logic                                       wbWe_i,
    input  isaPkg::gprNum_t                            wbNum_i,
    input  isaPkg::word_t                              wbData_i,
    input  logic                                       pbaWe_i,
    input  isaPkg::gprNum_t                            pbaNum_i,
    input  isaPkg::word_t                              pbaData_i,
    input  issuePkg::stageWrite_t [`STAGE_COUNT-1:0]   pipeWrites_i,
    input  logic                                       downstreamDanger_i,
    input  logic                                       allowIn_i,
    output logic                                       upValid_o,
    output logic                                       downValid_o,
    output issuePkg::issueBundle_t                     upIssue_o,
    output issuePkg::issueBundle_t                     downIssue_o,
    output logic                                       stopFetch_o
);
    issuePkg::queueEntry_t  [`ISSUE_WIDTH-1:0] head;
    isaPkg::decodedInst_t   [`ISSUE_WIDTH-1:0] decoded;
    issuePkg::issueBundle_t [`ISSUE_WIDTH-1:0] bundle;
    logic [1:0]                                headCount;
    logic [1:0]                                popCount;
    issuePkg::issueMode_t                      mode;
    isaPkg::gprNum_t        [3:0]              readNum;
    isaPkg::word_t          [3:0]              readData;
    issuePkg::fwdSel_t      [3:0]              fwdSel;

    instQueue queue (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .pushValid_i  (fetchValid_i),
        .pushPacket_i (fetchPacket_i),
        .popCount_i   (popCount),
        .head_o       (head),
        .headCount_o  (headCount),
        .stopFetch_o  (stopFetch_o)
    );

    //////////////////////////////////////////////////
    // per slot decode and bundle
    //////////////////////////////////////////////////
    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : gSlot
        instDecoder decoder (
            .inst_i    (head[i].inst),
            .decoded_o (decoded[i])
        );

        assign readNum[2*i]   = decoded[i].readNum0;
        assign readNum[2*i+1] = decoded[i].readNum1;

        assign bundle[i] = '{
            pc:            head[i].pc,
            aluOp:         decoded[i].aluOp,
            writeNum:      decoded[i].writeNum,
            readData0:     readData[2*i],
            readData1:     readData[2*i+1],
            operand0:      decoded[i].shiftAmount,
            operand1:      decoded[i].immediate,
            operand0IsReg: decoded[i].operand0IsReg,
            operand1IsReg: decoded[i].operand1IsReg,
            fwdSel0:       fwdSel[2*i],
            fwdSel1:       fwdSel[2*i+1]
        };
    end

    issueArbiter arbiter (
        .headCount_i (headCount),
        .older_i     (decoded[0]),
        .younger_i   (decoded[1]),
        .mode_o      (mode)
    );

    regFile gpr (
        .clk        (clk),
        .rst_i      (rst_i),
        .readNum_i  (readNum),
        .readData_o (readData),
        .wbWe_i     (wbWe_i),
        .wbNum_i    (wbNum_i),
        .wbData_i   (wbData_i),
        .pbaWe_i    (pbaWe_i),
        .pbaNum_i   (pbaNum_i),
        .pbaData_i  (pbaData_i)
    );

    hazardUnit hazard (
        .mode_i             (mode),
        .up_i               (decoded[0]),
        .down_i             (decoded[1]),
        .pipeWrites_i       (pipeWrites_i),
        .downstreamDanger_i (downstreamDanger_i),
        .allowIn_i          (allowIn_i),
        .flush_i            (flush_i),
        .fwdSel_o           (fwdSel),
        .upValid_o          (upValid_o),
        .downValid_o        (downValid_o),
        .popCount_o         (popCount)
    );

    assign upIssue_o   = bundle[0];
    assign downIssue_o = bundle[1];

endmodule

// File: test/decodeStageTb.sv
// decode stage testbench
`timescale 1ns/10ps
`include "decode_cfg.svh"

module decodeStageTb;
    localparam int WAIT_LIMIT   = 20;     // cycles any wait may take
    localparam int RECORD_LIMIT = 500;

    logic                                     clk;
    logic                                     rst_i;
    logic                                     fetchValid_i;
    issuePkg::fetchPacket_t                   fetchPacket_i;
    logic                                     flush_i;
    logic                                     wbWe_i;
    isaPkg::gprNum_t                          wbNum_i;
    isaPkg::word_t                            wbData_i;
    logic                                     pbaWe_i;
    isaPkg::gprNum_t                          pbaNum_i;
    isaPkg::word_t                            pbaData_i;
    issuePkg::stageWrite_t [`STAGE_COUNT-1:0] pipeWrites_i;
    logic                                     downstreamDanger_i;
    logic                                     allowIn_i;
    logic                                     upValid_o;
    logic                                     downValid_o;
    issuePkg::issueBundle_t                   upIssue_o;
    issuePkg::issueBundle_t                   downIssue_o;
    logic                                     stopFetch_o;

    decodeStage dut (
        .clk                (clk),
        .rst_i              (rst_i),
        .fetchValid_i       (fetchValid_i),
        .fetchPacket_i      (fetchPacket_i),
        .flush_i            (flush_i),
        .wbWe_i             (wbWe_i),
        .wbNum_i            (wbNum_i),
        .wbData_i           (wbData_i),
        .pbaWe_i            (pbaWe_i),
        .pbaNum_i           (pbaNum_i),
        .pbaData_i          (pbaData_i),
        .pipeWrites_i       (pipeWrites_i),
        .downstreamDanger_i (downstreamDanger_i),
        .allowIn_i          (allowIn_i),
        .upValid_o          (upValid_o),
        .downValid_o        (downValid_o),
        .upIssue_o          (upIssue_o),
        .downIssue_o        (downIssue_o),
        .stopFetch_o        (stopFetch_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // reporting and compares
    //////////////////////////////////////////////////
    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "testbench stopped");
    endtask

    task automatic checkValid(input logic expUp, input logic expDown);
        if ({upValid_o, downValid_o} !== {expUp, expDown})
            stopOnError($sformatf("Mismatch at %0t: valids up/down %b%b, expected %b%b",
                $time, upValid_o, downValid_o, expUp, expDown));
    endtask

    task automatic checkBundle(input int slot, input issuePkg::issueBundle_t exp);
        issuePkg::issueBundle_t got;
        got = (slot == 0) ? upIssue_o : downIssue_o;
        if (got !== exp)
            stopOnError($sformatf("Mismatch at %0t: slot %0d bundle %h, expected %h",
                $time, slot, got, exp));
    endtask

    task automatic checkStop(input logic exp);
        if (stopFetch_o !== exp)
            stopOnError($sformatf("Mismatch at %0t: stopFetch_o %b, expected %b",
                $time, stopFetch_o, exp));
    endtask

    // fetch strobe and register writes last one cycle
    task automatic runCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
            fetchValid_i = 1'b0;
            wbWe_i       = 1'b0;
            pbaWe_i      = 1'b0;
        end
    endtask

    task automatic waitFetchOpen();
        int i;
        i = 0;
        while (stopFetch_o !== 1'b0 && i < WAIT_LIMIT) begin
            @(negedge clk);
            i++;
        end
        if (stopFetch_o !== 1'b0)
            stopOnError("stopFetch_o did not go low after reset");
    endtask

    //////////////////////////////////////////////////
    // record driven stimulus
    //////////////////////////////////////////////////
    initial begin
        int                     fd;
        int                     n;
        int                     records;
        logic [63:0]            kind;
        logic [8*200-1:0]       line;
        logic [31:0]            f [13];
        logic [1:0]             expValid;
        logic                   expStop;
        int                     bundleCount;
        logic [1:0]             haveBundle;
        issuePkg::issueBundle_t expBundle [2];

        fetchValid_i       = 1'b0;
        fetchPacket_i      = '0;
        flush_i            = 1'b0;
        wbWe_i             = 1'b0;
        wbNum_i            = '0;
        wbData_i           = '0;
        pbaWe_i            = 1'b0;
        pbaNum_i           = '0;
        pbaData_i          = '0;
        pipeWrites_i       = '0;
        downstreamDanger_i = 1'b0;
        allowIn_i          = 1'b1;
        rst_i              = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        waitFetchOpen();

        fd = $fopen("test/decodeTests.txt", "r");
        if (fd == 0) stopOnError("could not open test/decodeTests.txt");
        records = 0;
        while (!$feof(fd) && records < RECORD_LIMIT) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) break;
            records++;
            case (kind)
                "#": n = $fgets(line, fd);
                "F": begin                                 // fetch packet
                    n = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                    if (n != 6) stopOnError("malformed fetch record in test file");
                    fetchPacket_i.basePc    = f[0];
                    fetchPacket_i.instCount = f[1][2:0];
                    for (int k = 0; k < `FETCH_WIDTH; k++) begin
                        fetchPacket_i.inst[k] = f[2+k];
                    end
                    fetchValid_i = 1'b1;
                end
                "W": begin                                 // writeback ports
                    n = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                    if (n != 6) stopOnError("malformed register write record in test file");
                    wbWe_i    = f[0][0];
                    wbNum_i   = f[1][4:0];
                    wbData_i  = f[2];
                    pbaWe_i   = f[3][0];
                    pbaNum_i  = f[4][4:0];
                    pbaData_i = f[5];
                end
                "D": begin                                 // downstream state
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                    if (n != 11) stopOnError("malformed downstream record in test file");
                    for (int s = 0; s < `STAGE_COUNT; s++) begin
                        pipeWrites_i[s].writeNum = f[2*s][4:0];
                        pipeWrites_i[s].ready    = f[2*s+1][0];
                    end
                    downstreamDanger_i = f[8][0];
                    allowIn_i          = f[9][0];
                    flush_i            = f[10][0];
                end
                "S": begin
                    n = $fscanf(fd, "%d", f[0]);
                    if (n != 1) stopOnError("malformed step record in test file");
                    runCycles(f[0]);
                end
                "E": begin                                 // expectation plus bundles
                    n = $fscanf(fd, "%h %h %h %d", f[0], f[1], f[2], f[3]);
                    if (n != 4) stopOnError("malformed expectation record in test file");
                    expValid    = {f[0][0], f[1][0]};
                    expStop     = f[2][0];
                    bundleCount = f[3];
                    haveBundle  = '0;
                    for (int b = 0; b < bundleCount; b++) begin
                        n = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h", kind,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                            f[10], f[11]);
                        if (n != 13 || kind != "B" || f[0] > 1)
                            stopOnError("malformed bundle record in test file");
                        expBundle[f[0]].pc            = f[1];
                        expBundle[f[0]].aluOp         = isaPkg::aluOp_e'(f[2][3:0]);
                        expBundle[f[0]].writeNum      = f[3][4:0];
                        expBundle[f[0]].readData0     = f[4];
                        expBundle[f[0]].readData1     = f[5];
                        expBundle[f[0]].operand0      = f[6];
                        expBundle[f[0]].operand1      = f[7];
                        expBundle[f[0]].operand0IsReg = f[8][0];
                        expBundle[f[0]].operand1IsReg = f[9][0];
                        expBundle[f[0]].fwdSel0       = f[10][`STAGE_COUNT:0];
                        expBundle[f[0]].fwdSel1       = f[11][`STAGE_COUNT:0];
                        haveBundle[f[0]]              = 1'b1;
                    end
                    #4;                                    // settled, before the rising edge
                    checkValid(expValid[1], expValid[0]);
                    checkStop(expStop);
                    for (int b = 0; b < 2; b++) begin
                        if (haveBundle[b]) checkBundle(b, expBundle[b]);
                    end
                    @(negedge clk);
                    fetchValid_i = 1'b0;
                    wbWe_i       = 1'b0;
                    pbaWe_i      = 1'b0;
                end
                default: stopOnError($sformatf("unknown record kind %0s in test file", kind));
            endcase
        end
        $fclose(fd);
        if (records >= RECORD_LIMIT) begin
            stopOnError("test file has too many records");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+include
src/isaPkg.sv
src/issuePkg.sv
src/instQueue.sv
src/instDecoder.sv
src/issueArbiter.sv
src/regFile.sv
src/hazardUnit.sv
src/decodeStage.sv
test/decodeStageTb.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - include
    files:
      - src/isaPkg.sv
      - src/issuePkg.sv
      - src/instQueue.sv
      - src/instDecoder.sv
      - src/issueArbiter.sv
      - src/regFile.sv
      - src/hazardUnit.sv
      - src/decodeStage.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/decodeStageTb.sv

// File: test/decodeTests.txt
# F basePc count inst0..inst3 | W wbWe wbNum wbData pbaWe pbaNum pbaData | S cycles
# D w0 r0 w1 r1 w2 r2 w3 r3 danger allow flush | E up down stop bundles, then B lines
# B slot pc aluOp writeNum readData0 readData1 operand0 operand1 isReg0 isReg1 sel0 sel1
W 1 01 00000011 1 02 00000022
S 1
W 1 03 00000033 1 04 00000044
S 1
# two independent instructions issue together
F 00001000 2 00222821 2466fffc 00000000 00000000
S 1
E 1 1 0 2
B 0 00001000 1 05 00000011 00000022 00000000 00000000 1 1 10 10
B 1 00001004 1 06 00000033 00000000 0000001f fffffffc 1 0 10 10
E 0 0 0 0
# dependent pair issues one at a time
F 00002000 2 00223825 00e44026 00000000 00000000
S 1
E 1 0 0 1
B 0 00002000 4 07 00000011 00000022 00000000 00000000 1 1 10 10
E 1 0 0 1
B 0 00002004 5 08 00000000 00000044 00000000 00000000 1 1 10 10
E 0 0 0 0
# forwarding picks the youngest ready stage
D 00 0 02 0 02 0 01 1 0 1 0
F 00003000 1 00414823 00000000 00000000 00000000
S 1
E 0 0 0 1
B 0 00003000 2 09 00000022 00000011 00000000 00000000 1 1 00 08
E 0 0 0 0
D 00 0 02 1 02 0 01 1 0 1 0
E 1 0 0 1
B 0 00003000 2 09 00000022 00000011 00000000 00000000 1 1 02 08
D 00 0 00 0 00 0 00 0 0 1 0
E 0 0 0 0
# danger and allowIn hold the head
F 00004000 1 302a8001 00000000 00000000 00000000
S 1
D 00 0 00 0 00 0 00 0 1 1 0
E 0 0 0 0
E 0 0 0 0
D 00 0 00 0 00 0 00 0 0 0 0
E 0 0 0 0
D 00 0 00 0 00 0 00 0 0 1 0
E 1 0 0 1
B 0 00004000 3 0a 00000011 00000000 00000000 00008001 1 0 10 10
E 0 0 0 0
# same cycle write bypass, pba beats wb
F 00006000 1 016c682a 00000000 00000000 00000000
S 1
W 1 0b aaaa0000 1 0b 5555ffff
E 1 0 0 1
B 0 00006000 6 0d 5555ffff 00000000 00000000 00000000 1 1 10 10
F 00006100 1 016c682a 00000000 00000000 00000000
S 1
W 1 0c 0000cccc 0 00 00000000
E 1 0 0 1
B 0 00006100 6 0d 5555ffff 0000cccc 00000000 00000000 1 1 10 10
# fill the queue, then flush
D 00 0 00 0 00 0 00 0 0 0 0
F 00005000 4 00000000 00000000 00000000 00000000
S 1
F 00005010 4 00000000 00000000 00000000 00000000
S 1
F 00005020 4 00000000 00000000 00000000 00000000
S 1
E 0 0 0 0
F 00005030 4 00000000 00000000 00000000 00000000
S 1
E 0 0 1 0
D 00 0 00 0 00 0 00 0 0 1 1
E 0 0 1 0
D 00 0 00 0 00 0 00 0 0 1 0
E 0 0 0 0
